// File: Bender.yml
package:
  name: cart_loader

sources:
  - hw/host_pkg.sv
  - hw/cart_pkg.sv
  - hw/ioctl_word_stage.sv
  - hw/rom_header_probe.sv
  - hw/cheat_code_packer.sv
  - hw/backup_sync_engine.sv
  - hw/cart_loader_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_cart_loader.sv

// File: hw/backup_sync_engine.sv
// Backup RAM sequencer, tracks unsaved writes and moves save RAM to and from disk by sector
module backup_sync_engine (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          cart_active,
	input  logic [cart_pkg::MASK_W-1:0]   ram_mask,
	input  logic                          img_mounted,
	input  logic                          img_readonly,
	input  logic                          img_nonempty,
	input  logic                          bsram_write,
	input  logic                          osd_open,
	input  logic                          autosave,
	input  logic                          load_req,
	input  logic                          save_req,
	input  logic                          sd_ack,
	output logic                          sd_rd,
	output logic                          sd_wr,
	output logic [host_pkg::SD_LBA_W-1:0] sd_lba,
	output logic                          bk_busy,
	output logic                          bk_loading,
	output logic                          bk_pending,
	output logic                          bk_enabled
);

	localparam int LW = host_pkg::SD_LBA_W;

	host_pkg::backup_state_e state;

	logic          cart_active_q;
	logic          ack_q;
	logic          load_lvl;
	logic          save_lvl;
	logic          load_q;
	logic          save_q;
	logic          start_load;
	logic          start_save;
	logic [LW-1:0] last_lba;

	assign bk_busy  = (state == host_pkg::bk_busy);
	assign last_lba = LW'(ram_mask >> host_pkg::SECTOR_SHIFT);

	// Menu requests, and autosave once the OSD opens with unsaved data
	assign load_lvl = load_req & bk_enabled;
	assign save_lvl = (save_req | (bk_pending & osd_open & autosave)) & bk_enabled;

	// End of a cartridge download pulls in any existing save file
	assign start_load = (load_lvl & ~load_q)
		| (cart_active_q & ~cart_active & img_nonempty & bk_enabled);
	assign start_save = save_lvl & ~save_q & ~start_load;

	// ====================
	// Enable and pending
	// ====================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_q <= 1'b0;
			bk_enabled    <= 1'b0;
			bk_pending    <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			if (cart_active && !cart_active_q)
				bk_enabled <= 1'b0;
			// Save image is mounted by the host before the download ends
			if (cart_active && img_mounted && !img_readonly)
				bk_enabled <= (ram_mask != '0);
			if (bk_enabled && !osd_open && bsram_write)
				bk_pending <= 1'b1;
			else if (bk_busy)
				bk_pending <= 1'b0;
		end
	end

	// ====================
	// Sector sequencer
	// ====================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= host_pkg::bk_idle;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			bk_loading <= 1'b0;
			ack_q      <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
		end else begin
			ack_q  <= sd_ack;
			load_q <= load_lvl;
			save_q <= save_lvl;

			// Host has taken the request
			if (sd_ack && !ack_q) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				host_pkg::bk_idle: begin
					if (start_load || start_save) begin
						state      <= host_pkg::bk_busy;
						bk_loading <= start_load;
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
					end
				end
				default: begin
					// Sector done once ack falls
					if (ack_q && !sd_ack) begin
						if (sd_lba >= last_lba) begin
							state      <= host_pkg::bk_idle;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
			endcase
		end
	end

	a_one_dir: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr))
		else $error("read and write requested together");

	a_lba_hold: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd_rd || sd_wr) |=> !(sd_rd || sd_wr) || $stable(sd_lba))
		else $error("sd_lba changed during a request");

endmodule

// File: hw/cart_loader_top.sv
// Cartridge loader top, chains the word stage into header, cheat and backup blocks
module cart_loader_top #(
	parameter logic [7:0] CODE_INDEX = 8'hff
) (
	input  logic                              clk_sys,
	input  logic                              RESET,

	// Host download stream
	input  logic                              dl_active,
	input  logic [7:0]                        dl_index,
	input  logic [host_pkg::IOCTL_ADDR_W-1:0] dl_addr,
	input  logic [host_pkg::IOCTL_DATA_W-1:0] dl_data,
	input  logic                              dl_wr,
	output logic                              code_active,

	// Header results
	input  cart_pkg::hdr_mode_e               hdr_mode,
	input  cart_pkg::region_sel_e             region_sel,
	output logic [7:0]                        rom_type,
	output logic [cart_pkg::MASK_W-1:0]       rom_mask,
	output logic [cart_pkg::MASK_W-1:0]       ram_mask,
	output logic                              pal,

	// Cheat codes
	output logic [127:0]                      code_word,
	output logic                              code_valid,
	output logic                              code_clear,

	// Save RAM backup
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic                              img_nonempty,
	input  logic                              bsram_write,
	input  logic                              osd_open,
	input  logic                              autosave,
	input  logic                              load_req,
	input  logic                              save_req,
	input  logic                              sd_ack,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic [host_pkg::SD_LBA_W-1:0]     sd_lba,
	output logic                              bk_busy,
	output logic                              bk_loading,
	output logic                              bk_pending,
	output logic                              bk_enabled
);

	host_pkg::word_kind_e              word_kind;
	logic [host_pkg::IOCTL_ADDR_W-1:0] word_addr;
	logic [host_pkg::IOCTL_DATA_W-1:0] word_data;
	logic                              cart_active;

	ioctl_word_stage #(
		.CODE_INDEX(CODE_INDEX)
	) u_word_stage (
		.clk_sys(clk_sys), .RESET(RESET),
		.dl_active(dl_active), .dl_index(dl_index), .dl_addr(dl_addr),
		.dl_data(dl_data), .dl_wr(dl_wr),
		.word_kind(word_kind), .word_addr(word_addr), .word_data(word_data),
		.cart_active(cart_active), .code_active(code_active)
	);

	rom_header_probe u_header (
		.clk_sys(clk_sys), .RESET(RESET),
		.word_kind(word_kind), .word_addr(word_addr), .word_data(word_data),
		.cart_active(cart_active), .hdr_mode(hdr_mode), .region_sel(region_sel),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	cheat_code_packer u_cheat (
		.clk_sys(clk_sys), .RESET(RESET),
		.word_kind(word_kind), .word_addr(word_addr), .word_data(word_data),
		.cart_active(cart_active),
		.code_word(code_word), .code_valid(code_valid), .code_clear(code_clear)
	);

	backup_sync_engine u_backup (
		.clk_sys(clk_sys), .RESET(RESET),
		.cart_active(cart_active), .ram_mask(ram_mask),
		.img_mounted(img_mounted), .img_readonly(img_readonly),
		.img_nonempty(img_nonempty), .bsram_write(bsram_write),
		.osd_open(osd_open), .autosave(autosave),
		.load_req(load_req), .save_req(save_req), .sd_ack(sd_ack),
		.sd_rd(sd_rd), .sd_wr(sd_wr), .sd_lba(sd_lba),
		.bk_busy(bk_busy), .bk_loading(bk_loading),
		.bk_pending(bk_pending), .bk_enabled(bk_enabled)
	);

endmodule

// File: hw/cart_pkg.sv
// Cartridge header definitions for layout modes, region select and size decoding
package cart_pkg;

	// Width of the ROM and save RAM address masks
	localparam int MASK_W = 24;

	// Copier header in front of the image, skipped by the layout offsets
	localparam int COPIER_BYTES = 512;

	// ROM size code when the image carries none (4 MB)
	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'd12;

	// ====================
	// Header layouts
	// ====================

	typedef enum logic [2:0] {
		hdr_auto,
		hdr_none,
		hdr_lorom,
		hdr_hirom,
		hdr_exhirom
	} hdr_mode_e;

	// Size field of the internal header for each layout
	// ROM size code sits in bits 11:8, RAM size code two bytes later in bits 3:0
	localparam int SIZE_OFS_LOROM   = 'h7FD6 + COPIER_BYTES;
	localparam int SIZE_OFS_HIROM   = 'hFFD6 + COPIER_BYTES;
	localparam int SIZE_OFS_EXHIROM = 'h40FFD6 + COPIER_BYTES;

	// ====================
	// Video region
	// ====================

	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal
	} region_sel_e;

endpackage

// File: hw/cheat_code_packer.sv
// Cheat packer, gathers eight download words into one 128-bit code and strobes it out
module cheat_code_packer (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  host_pkg::word_kind_e              word_kind,
	input  logic [host_pkg::IOCTL_ADDR_W-1:0] word_addr,
	input  logic [host_pkg::IOCTL_DATA_W-1:0] word_data,
	input  logic                              cart_active,
	output logic [127:0]                      code_word,
	output logic                              code_valid,
	output logic                              code_clear
);

	logic code_wr;
	logic cart_active_q;

	assign code_wr = (word_kind == host_pkg::kind_code);

	// Layout is flags, address, compare, replace from the top down
	// Each field arrives low half first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (word_addr[3:0])
				4'd0:  code_word[111:96]  <= word_data;
				4'd2:  code_word[127:112] <= word_data;
				4'd4:  code_word[79:64]   <= word_data;
				4'd6:  code_word[95:80]   <= word_data;
				4'd8:  code_word[47:32]   <= word_data;
				4'd10: code_word[63:48]   <= word_data;
				4'd12: code_word[15:0]    <= word_data;
				4'd14: code_word[31:16]   <= word_data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid    <= 1'b0;
			code_clear    <= 1'b0;
			cart_active_q <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			// Replace high word is the last one of a code
			code_valid    <= code_wr && word_addr[3:0] == 4'd14;
			// A new cheat file or a new cartridge drops the old code list
			code_clear    <= (code_wr && word_addr == '0) || (cart_active && !cart_active_q);
		end
	end

	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid held longer than one cycle");

endmodule

// File: hw/host_pkg.sv
// Host side definitions for the download stream and the backup disk transfers
package host_pkg;

	// ====================
	// Download stream
	// ====================

	// Byte address of the download file
	localparam int IOCTL_ADDR_W = 25;

	// One download transfer carries a 16-bit word
	localparam int IOCTL_DATA_W = 16;

	// Kind of content carried by a registered download word
	typedef enum logic [1:0] {
		kind_none,
		kind_cart,
		kind_code
	} word_kind_e;

	// ====================
	// Backup disk
	// ====================

	localparam int SD_LBA_W = 32;

	// Sectors are 512 bytes
	localparam int SECTOR_SHIFT = 9;

	typedef enum logic {
		bk_idle,
		bk_busy
	} backup_state_e;

endpackage

// File: hw/ioctl_word_stage.sv
// Download word stage, registers each host word and tags it as cartridge or cheat data
module ioctl_word_stage #(
	parameter logic [7:0] CODE_INDEX = 8'hff
) (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              dl_active,
	input  logic [7:0]                        dl_index,
	input  logic [host_pkg::IOCTL_ADDR_W-1:0] dl_addr,
	input  logic [host_pkg::IOCTL_DATA_W-1:0] dl_data,
	input  logic                              dl_wr,
	output host_pkg::word_kind_e              word_kind,
	output logic [host_pkg::IOCTL_ADDR_W-1:0] word_addr,
	output logic [host_pkg::IOCTL_DATA_W-1:0] word_data,
	output logic                              cart_active,
	output logic                              code_active
);

	logic is_code;

	// Cheat files come down on their own menu index
	assign is_code = (dl_index == CODE_INDEX);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			word_kind   <= host_pkg::kind_none;
			cart_active <= 1'b0;
			code_active <= 1'b0;
		end else begin
			cart_active <= dl_active & ~is_code;
			code_active <= dl_active & is_code;
			if (dl_wr && dl_active)
				word_kind <= is_code ? host_pkg::kind_code : host_pkg::kind_cart;
			else
				word_kind <= host_pkg::kind_none;
		end
	end

	// Address and data only matter while word_kind marks a word
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			word_addr <= dl_addr;
			word_data <= dl_data;
		end
	end

	a_one_stream: assert property (@(posedge clk_sys) disable iff (RESET)
		!(cart_active && code_active))
		else $error("cart and cheat downloads active together");

endmodule

// File: hw/rom_header_probe.sv
// Header probe, picks ROM type, size masks and video region out of the cartridge image
module rom_header_probe (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  host_pkg::word_kind_e              word_kind,
	input  logic [host_pkg::IOCTL_ADDR_W-1:0] word_addr,
	input  logic [host_pkg::IOCTL_DATA_W-1:0] word_data,
	input  logic                              cart_active,
	input  cart_pkg::hdr_mode_e               hdr_mode,
	input  cart_pkg::region_sel_e             region_sel,
	output logic [7:0]                        rom_type,
	output logic [cart_pkg::MASK_W-1:0]       rom_mask,
	output logic [cart_pkg::MASK_W-1:0]       ram_mask,
	output logic                              pal
);

	localparam int AW = host_pkg::IOCTL_ADDR_W;
	localparam logic [cart_pkg::MASK_W-1:0] MASK_BASE = 1024;

	logic          cart_wr;
	logic          size_forced;
	logic [AW-1:0] size_ofs;
	logic [AW-1:0] ram_ofs;
	logic [3:0]    rom_size;
	logic [3:0]    ram_size;
	logic          rom_region;

	assign cart_wr = (word_kind == host_pkg::kind_cart);
	assign ram_ofs = size_ofs + AW'(2);

	// Where the internal header sits for a forced layout
	always_comb begin
		size_forced = 1'b1;
		size_ofs    = '0;
		case (hdr_mode)
			cart_pkg::hdr_lorom:   size_ofs = AW'(cart_pkg::SIZE_OFS_LOROM);
			cart_pkg::hdr_hirom:   size_ofs = AW'(cart_pkg::SIZE_OFS_HIROM);
			cart_pkg::hdr_exhirom: size_ofs = AW'(cart_pkg::SIZE_OFS_EXHIROM);
			default:               size_forced = 1'b0;
		endcase
	end

	// ====================
	// Header fields
	// ====================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
		end else if (cart_wr) begin
			if (word_addr == '0) begin
				rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Loader header packs both size codes into the low byte
				if (hdr_mode == cart_pkg::hdr_auto && word_data[7:0] != 8'd0)
					{ram_size, rom_size} <= word_data[7:0];
				case (hdr_mode)
					cart_pkg::hdr_auto:    rom_type <= word_data[15:8];
					cart_pkg::hdr_hirom:   rom_type <= 8'd1;
					cart_pkg::hdr_exhirom: rom_type <= 8'd2;
					default:               rom_type <= 8'd0;
				endcase
			end
			if (word_addr == AW'(2))
				rom_region <= word_data[8];
			if (size_forced && word_addr == size_ofs)
				rom_size <= word_data[11:8];
			if (size_forced && word_addr == ram_ofs)
				ram_size <= word_data[3:0];
		end
	end

	// Masks follow the size codes one cycle later
	always_ff @(posedge clk_sys) begin
		rom_mask <= (MASK_BASE << rom_size) - 1'b1;
		ram_mask <= (ram_size != 4'd0) ? (MASK_BASE << ram_size) - 1'b1 : '0;
	end

	// ====================
	// Video region
	// ====================

	// Held during a download so the video timing does not flip mid load
	always_ff @(posedge clk_sys) begin
		if (RESET)
			pal <= 1'b0;
		else if (!cart_active) begin
			if (region_sel == cart_pkg::region_auto)
				pal <= rom_region;
			else
				pal <= (region_sel == cart_pkg::region_pal);
		end
	end

endmodule

// File: tb.f
+incdir+testbench
hw/host_pkg.sv
hw/cart_pkg.sv
hw/ioctl_word_stage.sv
hw/rom_header_probe.sv
hw/cheat_code_packer.sv
hw/backup_sync_engine.sv
hw/cart_loader_top.sv
testbench/tb_cart_loader.sv

// File: testbench/tb_ref_model.svh
// Reference model for header masks, ROM type, video region and cheat code packing
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
logic [31:0] lfsr_state = 32'hcd7a_87a8;

// One LFSR step for every bit handed out
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], lfsr_state[0]};
		lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'd0);
	end
	return r;
endfunction

// 1 KB shifted up by the size code, a zero RAM code means no save RAM at all
function automatic logic [cart_pkg::MASK_W-1:0] mask_ref(input logic [3:0] code, input bit is_ram);
	logic [cart_pkg::MASK_W-1:0] m;
	m = 24'd1024 << code;
	return (is_ram && code == 4'd0) ? '0 : m - 1'b1;
endfunction

function automatic logic [7:0] type_ref(input cart_pkg::hdr_mode_e mode, input logic [7:0] hdr);
	case (mode)
		cart_pkg::hdr_auto:    return hdr;
		cart_pkg::hdr_hirom:   return 8'd1;
		cart_pkg::hdr_exhirom: return 8'd2;
		default:               return 8'd0;
	endcase
endfunction

function automatic logic pal_ref(input cart_pkg::region_sel_e sel, input logic hdr_pal);
	return (sel == cart_pkg::region_auto) ? hdr_pal : (sel == cart_pkg::region_pal);
endfunction

// Words come low half first, fields are flags, address, compare, replace from the top
function automatic logic [127:0] code_ref(input logic [7:0][15:0] w);
	return {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
endfunction

`endif

// File: testbench/tb_cart_loader.sv
// Testbench for the cartridge loader, header decode, cheat packing and save RAM transfers
module tb_cart_loader;
	timeunit 1ns;
	timeprecision 1ps;

	logic                              clk_sys = 1'b0;
	logic                              RESET = 1'b1;
	logic                              dl_active = 1'b0;
	logic [7:0]                        dl_index = 8'd0;
	logic [host_pkg::IOCTL_ADDR_W-1:0] dl_addr = '0;
	logic [host_pkg::IOCTL_DATA_W-1:0] dl_data = '0;
	logic                              dl_wr = 1'b0;
	cart_pkg::hdr_mode_e               hdr_mode = cart_pkg::hdr_auto;
	cart_pkg::region_sel_e             region_sel = cart_pkg::region_auto;
	logic                              img_mounted = 1'b0;
	logic                              img_readonly = 1'b0;
	logic                              img_nonempty = 1'b0;
	logic                              bsram_write = 1'b0;
	logic                              osd_open = 1'b0;
	logic                              autosave = 1'b0;
	logic                              load_req = 1'b0;
	logic                              save_req = 1'b0;
	logic                              sd_ack = 1'b0;

	logic                              code_active, pal, code_valid, code_clear;
	logic                              sd_rd, sd_wr, bk_busy, bk_loading, bk_pending, bk_enabled;
	logic [7:0]                        rom_type;
	logic [cart_pkg::MASK_W-1:0]       rom_mask, ram_mask;
	logic [127:0]                      code_word;
	logic [host_pkg::SD_LBA_W-1:0]     sd_lba;

	// Expected values and the host disk log
	logic [127:0]                      expected_code = '0;
	logic                              hdr_pal_bit = 1'b0;
	int                                valid_count = 0;
	int                                clear_count = 0;
	int                                expected_sectors = 0;
	bit                                req_is_write [$];
	logic [host_pkg::SD_LBA_W-1:0]     req_lba [$];

	`include "tb_ref_model.svh"

	cart_loader_top u_cart_loader_top (.*);

	always #5 clk_sys = ~clk_sys;

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		assert (got === exp)
		else stop_on_error($sformatf("Fail %s got %0h expected %0h", name, got, exp));
	endtask

	// ====================
	// Download stream
	// ====================

	task automatic start_download(input logic [7:0] index);
		@(negedge clk_sys);
		dl_index  = index;
		dl_active = 1'b1;
	endtask

	// One host word, strobed for a single cycle
	task automatic write_word(input int addr, input logic [15:0] data);
		@(negedge clk_sys);
		dl_addr = host_pkg::IOCTL_ADDR_W'(addr);
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr   = 1'b0;
	endtask

	// Short gap before the host drops the download, then the header settles
	task automatic end_download;
		repeat (3) @(negedge clk_sys);
		dl_active = 1'b0;
		repeat (4) @(negedge clk_sys);
	endtask

	task automatic header_case(input cart_pkg::hdr_mode_e mode);
		logic [15:0] w0;
		logic [15:0] w2;
		logic [3:0]  rom_code;
		logic [3:0]  ram_code;
		int          ofs;
		w0       = 16'(rand_bits(16));
		w2       = 16'(rand_bits(16));
		rom_code = 4'(rand_bits(4));
		ram_code = 4'(rand_bits(4));
		case (mode)
			cart_pkg::hdr_hirom:   ofs = cart_pkg::SIZE_OFS_HIROM;
			cart_pkg::hdr_exhirom: ofs = cart_pkg::SIZE_OFS_EXHIROM;
			default:               ofs = cart_pkg::SIZE_OFS_LOROM;
		endcase
		hdr_mode    = mode;
		hdr_pal_bit = w2[8];
		start_download(8'd0);
		write_word(0, w0);
		write_word(2, w2);
		write_word(ofs, {4'h0, rom_code, 8'h00});
		write_word(ofs + 2, {12'h000, ram_code});
		end_download();
		// Auto mode takes sizes from the loader word, forced layouts from their own field
		if (mode == cart_pkg::hdr_none || (mode == cart_pkg::hdr_auto && w0[7:0] == 8'd0)) begin
			rom_code = cart_pkg::DEFAULT_ROM_SIZE;
			ram_code = 4'd0;
		end else if (mode == cart_pkg::hdr_auto) begin
			rom_code = w0[3:0];
			ram_code = w0[7:4];
		end
		check_value("rom_type", rom_type, type_ref(mode, w0[15:8]));
		check_value("rom_mask", rom_mask, mask_ref(rom_code, 1'b0));
		check_value("ram_mask", ram_mask, mask_ref(ram_code, 1'b1));
		check_value("pal", pal, pal_ref(region_sel, hdr_pal_bit));
	endtask

	task automatic region_case(input cart_pkg::region_sel_e sel);
		region_sel = sel;
		repeat (2) @(negedge clk_sys);
		check_value("pal", pal, pal_ref(sel, hdr_pal_bit));
	endtask

	task automatic cheat_case;
		logic [7:0][15:0] words;
		int               n;
		for (int i = 0; i < 8; i++)
			words[i] = 16'(rand_bits(16));
		expected_code = code_ref(words);
		valid_count   = 0;
		clear_count   = 0;
		start_download(8'hff);
		for (int i = 0; i < 8; i++)
			write_word(2 * i, words[i]);
		check_value("code_active", code_active, 1'b1);
		n = 0;
		while (valid_count == 0) begin
			@(negedge clk_sys);
			n++;
			if (n > 20)
				stop_on_error("Timeout waiting for code_valid after the last cheat word");
		end
		end_download();
		check_value("code_active", code_active, 1'b0);
		check_value("code_valid pulses", valid_count, 1);
		check_value("code_clear pulses", clear_count, 1);
	endtask

	// Outputs settle on the rising edge, so sample them on the falling one
	always @(negedge clk_sys) begin
		if (code_valid) begin
			valid_count++;
			check_value("code_word", code_word, expected_code);
		end
		if (code_clear)
			clear_count++;
	end

	// ====================
	// Host disk
	// ====================

	always @(negedge clk_sys) begin
		if (!RESET && (sd_rd || sd_wr) && !sd_ack)
			serve_sector();
	end

	task automatic serve_sector;
		int n;
		req_is_write.push_back(sd_wr);
		req_lba.push_back(sd_lba);
		repeat (1 + rand_bits(3)) @(negedge clk_sys);
		sd_ack = 1'b1;
		n = 0;
		while (sd_rd || sd_wr) begin
			@(negedge clk_sys);
			n++;
			if (n > 2)
				stop_on_error("Sector request still raised two cycles after sd_ack rose");
		end
		sd_ack = 1'b0;
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (bk_busy !== level) begin
			@(negedge clk_sys);
			n++;
			if (n > limit)
				stop_on_error($sformatf("Timeout waiting for bk_busy to become %0d", level));
		end
	endtask

	// One pass over the save RAM, lba 0 upwards, all in one direction
	task automatic check_sectors(input bit is_write, input int count);
		check_value("sector count", req_lba.size(), count);
		foreach (req_lba[i]) begin
			check_value("sd_wr", req_is_write[i], is_write);
			check_value("sd_lba", req_lba[i], i);
		end
		req_lba.delete();
		req_is_write.delete();
	endtask

	task automatic autoload_case;
		logic [3:0] ram_code;
		ram_code         = 4'd1 + 4'(rand_bits(1));
		expected_sectors = int'(mask_ref(ram_code, 1'b1) >> host_pkg::SECTOR_SHIFT) + 1;
		img_mounted      = 1'b1;
		img_nonempty     = 1'b1;
		hdr_mode         = cart_pkg::hdr_auto;
		start_download(8'd0);
		write_word(0, {8'h00, ram_code, 4'h8});
		end_download();
		wait_busy(1'b1, 20);
		check_value("bk_loading", bk_loading, 1'b1);
		wait_busy(1'b0, 400);
		check_value("bk_loading", bk_loading, 1'b0);
		check_sectors(1'b0, expected_sectors);
	endtask

	task automatic save_case(input int count);
		@(negedge clk_sys);
		bsram_write = 1'b1;
		@(negedge clk_sys);
		bsram_write = 1'b0;
		check_value("bk_pending", bk_pending, count != 0);
		save_req = 1'b1;
		@(negedge clk_sys);
		save_req = 1'b0;
		if (count != 0) begin
			wait_busy(1'b1, 20);
			wait_busy(1'b0, 400);
		end else begin
			repeat (20) @(negedge clk_sys);
		end
		check_value("bk_pending", bk_pending, 1'b0);
		check_sectors(1'b1, count);
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		repeat (5) @(negedge clk_sys);
		RESET = 1'b0;
		repeat (4) header_case(cart_pkg::hdr_auto);
		header_case(cart_pkg::hdr_lorom);
		header_case(cart_pkg::hdr_hirom);
		header_case(cart_pkg::hdr_exhirom);
		header_case(cart_pkg::hdr_none);
		region_case(cart_pkg::region_ntsc);
		region_case(cart_pkg::region_pal);
		region_case(cart_pkg::region_auto);
		cheat_case();
		autoload_case();
		save_case(expected_sectors);
		// Cartridge without save RAM keeps the backup engine off
		start_download(8'd0);
		write_word(0, 16'h0009);
		end_download();
		check_value("bk_enabled", bk_enabled, 1'b0);
		save_case(0);
		$display("All tests passed!");
		$finish;
	end

endmodule
